//--- all.f
+incdir+verif
hw/usb_pkg.sv
hw/token_decoder.sv
hw/ctrl_descriptor_ep.sv
hw/bulk_in_ep.sv
hw/tx_arbiter.sv
hw/packet_encoder.sv
hw/usb_device_top.sv
verif/tb_usb_device.sv

//--- hw/bulk_in_ep.sv
module bulk_in_ep (
  input  logic              clock,
  input  logic              areset_n,
  input  usb_pkg::token_t   token_i,
  input  logic              s_axis_tvalid_i,
  input  logic              s_axis_tlast_i,
  input  usb_pkg::byte_t    s_axis_tdata_i,
  output logic              s_axis_tready_o,
  output logic              req_o,
  output usb_pkg::tx_req_t  req_info_o,
  input  logic              ack_i,
  output usb_pkg::tx_beat_t beat_o,
  input  logic              beat_ready_i
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_SEND,
    S_RELEASE
  } state_t;

  typedef struct packed {
    logic           last;  // stored tlast
    usb_pkg::byte_t data;
  } fifo_entry_t;

  fifo_entry_t        mem [usb_pkg::FIFO_DEPTH];
  usb_pkg::fifo_ptr_t wr_ptr;
  usb_pkg::fifo_ptr_t rd_ptr;
  fifo_entry_t        head;
  logic               empty;
  logic               full;
  logic               push;
  logic               pop;

  state_t            state;
  usb_pkg::pkt_cnt_t cnt;
  logic              hsk_q;   // this request is a NAK
  logic              toggle;
  logic              hit;

  // pointers carry an extra wrap bit
  assign empty = wr_ptr == rd_ptr;
  assign full  = (wr_ptr[4] != rd_ptr[4]) && (wr_ptr[3:0] == rd_ptr[3:0]);
  assign head  = mem[rd_ptr[3:0]];

  assign s_axis_tready_o = !full;
  assign push            = s_axis_tvalid_i && !full;

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr[3:0]] <= {s_axis_tlast_i, s_axis_tdata_i};
    end
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  assign hit = token_i.strobe && (token_i.pid == usb_pkg::PID_IN) &&
               (token_i.endp == usb_pkg::EP_BULK);

  assign req_o               = state == S_SEND;
  assign req_info_o.hsk_only = hsk_q;
  assign req_info_o.pid      = hsk_q  ? usb_pkg::PID_NAK :
                               toggle ? usb_pkg::PID_DATA1 : usb_pkg::PID_DATA0;

  // an underrun mid-packet just stalls the beat
  assign beat_o.valid = req_o && !hsk_q && ack_i && !empty;
  assign beat_o.last  = head.last || (cnt == usb_pkg::pkt_cnt_t'(usb_pkg::MAX_PKT - 1));
  assign beat_o.data  = head.data;

  assign pop = beat_o.valid && beat_ready_i;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      state  <= S_IDLE;
      cnt    <= '0;
      hsk_q  <= 1'b0;
      toggle <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (hit) begin
            hsk_q <= empty;  // nothing queued, answer NAK
            cnt   <= '0;
            state <= S_SEND;
          end
        end
        S_SEND: begin
          if (hsk_q && ack_i) begin
            state <= S_RELEASE;  // handshake drops req at once, toggle kept
          end else if (pop) begin
            cnt <= cnt + 1'b1;
            if (beat_o.last) begin
              toggle <= ~toggle;
              state  <= S_RELEASE;
            end
          end
        end
        default: begin
          if (!ack_i) begin
            state <= S_IDLE;
          end
        end
      endcase
    end
  end

endmodule

//--- hw/ctrl_descriptor_ep.sv
module ctrl_descriptor_ep (
  input  logic              clock,
  input  logic              areset_n,
  input  usb_pkg::token_t   token_i,
  output logic              req_o,
  output usb_pkg::tx_req_t  req_info_o,
  input  logic              ack_i,
  output usb_pkg::tx_beat_t beat_o,
  input  logic              beat_ready_i
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_SEND,    // req high, beats while acked
    S_RELEASE  // req low, wait for ack to fall
  } state_t;

  state_t             state;
  usb_pkg::desc_ptr_t offset;  // kept across tokens
  usb_pkg::pkt_cnt_t  cnt;
  logic               toggle;  // 0 = DATA0
  logic               hit;
  logic               at_end;
  logic               take;

  assign hit = token_i.strobe && (token_i.pid == usb_pkg::PID_IN) &&
               (token_i.endp == usb_pkg::EP_CTRL);

  // final descriptor byte closes a short chunk
  assign at_end = offset == usb_pkg::desc_ptr_t'(usb_pkg::CONF_DESC_LEN - 1);

  assign req_o               = state == S_SEND;
  assign req_info_o.hsk_only = 1'b0;
  assign req_info_o.pid      = toggle ? usb_pkg::PID_DATA1 : usb_pkg::PID_DATA0;

  assign beat_o.valid = req_o && ack_i;
  assign beat_o.last  = at_end || (cnt == usb_pkg::pkt_cnt_t'(usb_pkg::MAX_PKT - 1));
  assign beat_o.data  = usb_pkg::CONF_DESC[{offset, 3'b000} +: 8];

  assign take = beat_o.valid && beat_ready_i;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      state  <= S_IDLE;
      offset <= '0;
      cnt    <= '0;
      toggle <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (hit) begin
            state <= S_SEND;
          end
        end
        S_SEND: begin
          if (take) begin
            offset <= at_end ? '0 : offset + 1'b1;  // wrap after 39 bytes
            cnt    <= beat_o.last ? '0 : cnt + 1'b1;
            if (beat_o.last) begin
              toggle <= ~toggle;
              state  <= S_RELEASE;
            end
          end
        end
        default: begin
          if (!ack_i) begin
            state <= S_IDLE;  // four-phase cycle complete
          end
        end
      endcase
    end
  end

endmodule

//--- hw/packet_encoder.sv
module packet_encoder (
  input  logic              clock,
  input  logic              areset_n,
  input  logic              start_i,
  input  usb_pkg::tx_req_t  info_i,
  input  usb_pkg::tx_beat_t beat_i,
  output logic              beat_ready_o,
  output logic              idle_o,
  input  logic              tx_ready_i,
  output logic              tx_valid_o,
  output logic              tx_last_o,
  output usb_pkg::byte_t    tx_data_o
);

  typedef enum logic [2:0] {
    E_IDLE,
    E_PID,
    E_PAYLOAD,
    E_CRC_LO,
    E_CRC_HI
  } state_t;

  state_t           state;
  usb_pkg::tx_req_t info_q;  // latched at start
  usb_pkg::crc16_t  crc_q;
  logic             pay_take;

  // reflected crc16, data lsb first
  function automatic usb_pkg::crc16_t crc16_byte(input usb_pkg::crc16_t crc,
                                                 input usb_pkg::byte_t  data);
    usb_pkg::crc16_t c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      if (c[0] ^ data[i]) begin
        c = (c >> 1) ^ usb_pkg::CRC16_POLY;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

  assign idle_o   = state == E_IDLE;
  assign pay_take = (state == E_PAYLOAD) && beat_i.valid && tx_ready_i;

  always_comb begin
    tx_valid_o   = 1'b0;
    tx_last_o    = 1'b0;
    tx_data_o    = '0;
    beat_ready_o = 1'b0;
    case (state)
      E_PID: begin
        tx_valid_o = 1'b1;
        tx_last_o  = info_q.hsk_only;             // NAK is one byte
        tx_data_o  = {~info_q.pid, info_q.pid};  // check nibble on top
      end
      E_PAYLOAD: begin
        tx_valid_o   = beat_i.valid;
        tx_data_o    = beat_i.data;
        beat_ready_o = tx_ready_i;  // ready passes straight back
      end
      E_CRC_LO: begin
        tx_valid_o = 1'b1;
        tx_data_o  = ~crc_q[7:0];
      end
      E_CRC_HI: begin
        tx_valid_o = 1'b1;
        tx_last_o  = 1'b1;
        tx_data_o  = ~crc_q[15:8];
      end
      default: begin
      end
    endcase
  end

  // request and crc datapath
  always_ff @(posedge clock) begin
    if (state == E_IDLE && start_i) begin
      info_q <= info_i;
      crc_q  <= usb_pkg::CRC16_INIT;
    end else if (pay_take) begin
      crc_q <= crc16_byte(crc_q, beat_i.data);  // payload only
    end
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      state <= E_IDLE;
    end else begin
      case (state)
        E_IDLE: begin
          if (start_i) begin
            state <= E_PID;
          end
        end
        E_PID: begin
          if (tx_ready_i) begin
            state <= info_q.hsk_only ? E_IDLE : E_PAYLOAD;
          end
        end
        E_PAYLOAD: begin
          if (pay_take && beat_i.last) begin
            state <= E_CRC_LO;
          end
        end
        E_CRC_LO: begin
          if (tx_ready_i) begin
            state <= E_CRC_HI;
          end
        end
        default: begin
          if (tx_ready_i) begin
            state <= E_IDLE;
          end
        end
      endcase
    end
  end

endmodule

//--- hw/token_decoder.sv
module token_decoder (
  input  logic            clock,
  input  logic            areset_n,
  input  logic            rx_valid_i,
  input  logic            rx_last_i,
  input  usb_pkg::byte_t  rx_data_i,
  output usb_pkg::token_t token_o
);

  typedef enum logic [1:0] {
    ST_PID,   // expecting the PID byte
    ST_ADDR,  // addr plus endp bit 0
    ST_ENDP,  // endp bits 3:1 and crc5
    ST_DROP   // too long, skip to rx_last_i
  } state_t;

  state_t         state;
  usb_pkg::byte_t pid_q;
  usb_pkg::byte_t addr_q;
  logic           pid_ok;
  logic           addr_ok;
  logic           accept;

  // high nibble must be the check nibble
  assign pid_ok  = (pid_q[7:4] == ~pid_q[3:0]) && (pid_q[3:0] == usb_pkg::PID_IN);
  assign addr_ok = addr_q[6:0] == usb_pkg::DEV_ADDR;

  // third byte carrying last, with everything before it good
  assign accept = rx_valid_i && rx_last_i && (state == ST_ENDP) && pid_ok && addr_ok;

  // byte capture
  always_ff @(posedge clock) begin
    if (rx_valid_i && state == ST_PID) begin
      pid_q <= rx_data_i;
    end
    if (rx_valid_i && state == ST_ADDR) begin
      addr_q <= rx_data_i;
    end
  end

  // byte position in the current packet
  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      state <= ST_PID;
    end else if (rx_valid_i) begin
      case (state)
        ST_PID:  state <= rx_last_i ? ST_PID : ST_ADDR;  // 1-byte packet dropped
        ST_ADDR: state <= rx_last_i ? ST_PID : ST_ENDP;  // 2-byte packet dropped
        ST_ENDP: state <= rx_last_i ? ST_PID : ST_DROP;
        default: state <= rx_last_i ? ST_PID : ST_DROP;
      endcase
    end
  end

  // one strobe per good IN token, the cycle after byte 3
  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      token_o <= '0;
    end else begin
      token_o.strobe <= accept;
      if (accept) begin
        token_o.pid  <= pid_q[3:0];
        token_o.endp <= {rx_data_i[2:0], addr_q[7]};  // endp split over two bytes
      end
    end
  end

endmodule

//--- hw/tx_arbiter.sv
module tx_arbiter (
  input  logic                    clock,
  input  logic                    areset_n,
  input  logic [1:0]              req_i,
  input  usb_pkg::tx_req_t [1:0]  req_info_i,
  input  usb_pkg::tx_beat_t [1:0] beat_i,
  output logic [1:0]              ack_o,
  output logic                    beat_ready_o,
  output logic                    enc_start_o,
  output usb_pkg::tx_req_t        enc_info_o,
  output usb_pkg::tx_beat_t       enc_beat_o,
  input  logic                    enc_beat_ready_i,
  input  logic                    enc_idle_i
);

  typedef enum logic {
    A_IDLE,
    A_GRANT  // ack held until the owner drops req
  } state_t;

  state_t state;
  logic   sel;      // current owner
  logic   prio;     // winner on a tie
  logic   pick;
  logic   granted;

  // lone requester wins, tie goes to prio
  assign pick    = (req_i == 2'b11) ? prio : req_i[1];
  assign granted = state == A_GRANT;

  // owner's request and beats onto the encoder
  assign enc_info_o = req_info_i[sel];

  always_comb begin
    enc_beat_o       = beat_i[sel];
    enc_beat_o.valid = beat_i[sel].valid && granted;
  end

  assign beat_ready_o = enc_beat_ready_i && granted;  // only the acked peer looks at it

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      state       <= A_IDLE;
      sel         <= 1'b0;
      prio        <= 1'b0;  // ep0 first after reset
      ack_o       <= '0;
      enc_start_o <= 1'b0;
    end else begin
      enc_start_o <= 1'b0;
      case (state)
        A_IDLE: begin
          if (|req_i && enc_idle_i) begin
            sel         <= pick;
            prio        <= ~pick;  // other side next time
            ack_o       <= pick ? 2'b10 : 2'b01;
            enc_start_o <= 1'b1;   // one start per grant
            state       <= A_GRANT;
          end
        end
        default: begin
          if (!req_i[sel]) begin
            ack_o <= '0;
            state <= A_IDLE;
          end
        end
      endcase
    end
  end

endmodule

//--- hw/usb_device_top.sv
module usb_device_top (
  input  logic           clock,
  input  logic           areset_n,
  // receive bytes from the PHY, no back-pressure
  input  logic           rx_valid_i,
  input  logic           rx_last_i,
  input  usb_pkg::byte_t rx_data_i,
  // bulk IN source
  input  logic           s_axis_tvalid_i,
  input  logic           s_axis_tlast_i,
  input  usb_pkg::byte_t s_axis_tdata_i,
  output logic           s_axis_tready_o,
  // transmit bytes towards the PHY
  input  logic           tx_ready_i,
  output logic           tx_valid_o,
  output logic           tx_last_o,
  output usb_pkg::byte_t tx_data_o
);

  usb_pkg::token_t         token;
  logic [1:0]              req;       // index 0 is ep0, 1 is ep1
  usb_pkg::tx_req_t [1:0]  req_info;
  usb_pkg::tx_beat_t [1:0] beat;
  logic [1:0]              ack;
  logic                    beat_ready;
  logic                    enc_start;
  usb_pkg::tx_req_t        enc_info;
  usb_pkg::tx_beat_t       enc_beat;
  logic                    enc_beat_ready;
  logic                    enc_idle;

  token_decoder u_token_decoder (
    .clock      (clock),
    .areset_n   (areset_n),
    .rx_valid_i (rx_valid_i),
    .rx_last_i  (rx_last_i),
    .rx_data_i  (rx_data_i),
    .token_o    (token)
  );

  ctrl_descriptor_ep u_ctrl_ep (
    .clock        (clock),
    .areset_n     (areset_n),
    .token_i      (token),
    .req_o        (req[0]),
    .req_info_o   (req_info[0]),
    .ack_i        (ack[0]),
    .beat_o       (beat[0]),
    .beat_ready_i (beat_ready)
  );

  bulk_in_ep u_bulk_ep (
    .clock           (clock),
    .areset_n        (areset_n),
    .token_i         (token),
    .s_axis_tvalid_i (s_axis_tvalid_i),
    .s_axis_tlast_i  (s_axis_tlast_i),
    .s_axis_tdata_i  (s_axis_tdata_i),
    .s_axis_tready_o (s_axis_tready_o),
    .req_o           (req[1]),
    .req_info_o      (req_info[1]),
    .ack_i           (ack[1]),
    .beat_o          (beat[1]),
    .beat_ready_i    (beat_ready)
  );

  tx_arbiter u_tx_arbiter (
    .clock            (clock),
    .areset_n         (areset_n),
    .req_i            (req),
    .req_info_i       (req_info),
    .beat_i           (beat),
    .ack_o            (ack),
    .beat_ready_o     (beat_ready),
    .enc_start_o      (enc_start),
    .enc_info_o       (enc_info),
    .enc_beat_o       (enc_beat),
    .enc_beat_ready_i (enc_beat_ready),
    .enc_idle_i       (enc_idle)
  );

  packet_encoder u_packet_encoder (
    .clock        (clock),
    .areset_n     (areset_n),
    .start_i      (enc_start),
    .info_i       (enc_info),
    .beat_i       (enc_beat),
    .beat_ready_o (enc_beat_ready),
    .idle_o       (enc_idle),
    .tx_ready_i   (tx_ready_i),
    .tx_valid_o   (tx_valid_o),
    .tx_last_o    (tx_last_o),
    .tx_data_o    (tx_data_o)
  );

endmodule

//--- hw/usb_pkg.sv
package usb_pkg;

  // widths that carry a meaning
  typedef logic [7:0]  byte_t;
  typedef logic [3:0]  pid_t;
  typedef logic [3:0]  endp_t;
  typedef logic [6:0]  addr_t;
  typedef logic [15:0] crc16_t;
  typedef logic [5:0]  desc_ptr_t;  // byte offset into the config descriptor
  typedef logic [2:0]  pkt_cnt_t;   // byte index inside one packet
  typedef logic [4:0]  fifo_ptr_t;  // 16 entries plus wrap bit

  // token and data PIDs, low nibble only
  localparam pid_t PID_IN    = 4'h9;
  localparam pid_t PID_DATA0 = 4'h3;
  localparam pid_t PID_DATA1 = 4'hB;
  localparam pid_t PID_NAK   = 4'hA;

  localparam addr_t DEV_ADDR = 7'h05;  // fixed address, no SET_ADDRESS
  localparam endp_t EP_CTRL  = 4'd0;
  localparam endp_t EP_BULK  = 4'd1;

  localparam int MAX_PKT       = 8;
  localparam int FIFO_DEPTH    = 16;
  localparam int CONF_DESC_LEN = 39;

  localparam crc16_t CRC16_INIT = 16'hFFFF;
  localparam crc16_t CRC16_POLY = 16'hA001;  // 0x8005 bit reversed

  // byte 0 lives in bits 7:0, so every group reads last byte first
  localparam logic [CONF_DESC_LEN*8-1:0] CONF_DESC = {
    56'h00_02_00_02_82_05_07,        // ep2 bulk in, 512 bytes
    56'h00_02_00_02_01_05_07,        // ep1 bulk out
    56'h00_02_00_02_81_05_07,        // ep1 bulk in
    72'h00_00_00_00_03_00_00_04_09,  // interface 0, three endpoints
    72'h32_C0_00_01_01_00_27_02_09   // configuration, total length 39
  };

  // one accepted IN token, broadcast to both endpoints
  typedef struct packed {
    logic  strobe;
    pid_t  pid;
    endp_t endp;
  } token_t;

  typedef struct packed {
    logic hsk_only;  // PID byte only, no payload
    pid_t pid;
  } tx_req_t;

  typedef struct packed {
    logic  valid;
    logic  last;
    byte_t data;
  } tx_beat_t;

endpackage

//--- verif/tb_usb_model.svh
`ifndef TB_USB_MODEL_SVH
`define TB_USB_MODEL_SVH

// descriptor in wire order, byte 0 leftmost
localparam logic [0:usb_pkg::CONF_DESC_LEN*8-1] DESC_REF = {
  72'h09_02_27_00_01_01_00_C0_32,  // configuration
  72'h09_04_00_00_03_00_00_00_00,  // interface 0
  56'h07_05_81_02_00_02_00,        // ep1 bulk in
  56'h07_05_01_02_00_02_00,        // ep1 bulk out
  56'h07_05_82_02_00_02_00         // ep2 bulk in
};

function automatic usb_pkg::byte_t pid_byte(input usb_pkg::pid_t pid);
  return {~pid, pid};  // check nibble on top
endfunction

function automatic usb_pkg::byte_t desc_byte(input int idx);
  return DESC_REF[idx*8 +: 8];
endfunction

// max packet or whatever is left of the descriptor
function automatic int chunk_len(input int offset);
  int left;
  left = usb_pkg::CONF_DESC_LEN - offset;
  return (left < usb_pkg::MAX_PKT) ? left : usb_pkg::MAX_PKT;
endfunction

// msb-first shifter on 0x8005, data fed lsb first, result mirrored and inverted
function automatic usb_pkg::crc16_t crc16_ref(input usb_pkg::byte_t data[$]);
  logic [15:0]     r;
  logic            fb;
  usb_pkg::crc16_t res;
  r = 16'hFFFF;
  foreach (data[i]) begin
    for (int b = 0; b < 8; b++) begin
      fb = r[15] ^ data[i][b];
      r  = {r[14:0], 1'b0};
      if (fb) begin
        r = r ^ 16'h8005;
      end
    end
  end
  for (int k = 0; k < 16; k++) begin
    res[k] = ~r[15-k];
  end
  return res;
endfunction

// endpoint hit by a token, -1 when the token is dropped
function automatic int token_target(input logic [23:0] tok, input int len);
  usb_pkg::byte_t pid_b;
  usb_pkg::byte_t b1;
  usb_pkg::byte_t b2;
  pid_b = tok[7:0];
  b1    = tok[15:8];
  b2    = tok[23:16];
  if (len != 3 || pid_b[7:4] != ~pid_b[3:0] || pid_b[3:0] != usb_pkg::PID_IN) begin
    return -1;
  end
  if (b1[6:0] != usb_pkg::DEV_ADDR) begin
    return -1;
  end
  return int'({b2[2:0], b1[7]});
endfunction

function automatic void append_packet(ref usb_pkg::byte_t bytes[$], ref int lens[$],
                                      input usb_pkg::pid_t pid, input logic hsk,
                                      input usb_pkg::byte_t payload[$]);
  usb_pkg::crc16_t crc;
  crc = crc16_ref(payload);
  bytes.push_back(pid_byte(pid));
  if (hsk) begin
    lens.push_back(1);  // pid byte alone
  end else begin
    foreach (payload[i]) begin
      bytes.push_back(payload[i]);
    end
    bytes.push_back(crc[7:0]);  // low byte first
    bytes.push_back(crc[15:8]);
    lens.push_back(payload.size() + 3);
  end
endfunction

`endif

//--- verif/tb_usb_device.sv
module tb_usb_device;
  timeunit 1ns;
  timeprecision 1ps;

  `include "tb_usb_model.svh"

  localparam int          RESET_CYCLES     = 16;
  localparam int          CYCLES_PER_ENTRY = 200;
  localparam int          PKT_WAIT         = 150;  // per entry, for all packets
  localparam int          SETTLE_CYCLES    = 12;   // covers the 8-cycle silence window
  localparam logic [23:0] TOK_EP1          = 24'h00_85_69;

  typedef struct packed {
    int          n_bulk;   // bytes preloaded into the bulk FIFO
    int          last_at;  // tlast on this byte, 0 for none
    logic [23:0] tok;      // byte 0 in bits 7:0
    int          tok_len;
    logic        follow_ep1;
    logic        rand_ready;
  } entry_t;

  logic           clock;
  logic           areset_n;
  logic           rx_valid_i;
  logic           rx_last_i;
  usb_pkg::byte_t rx_data_i;
  logic           s_axis_tvalid_i;
  logic           s_axis_tlast_i;
  usb_pkg::byte_t s_axis_tdata_i;
  logic           s_axis_tready_o;
  logic           tx_ready_i;
  logic           tx_valid_o;
  logic           tx_last_o;
  usb_pkg::byte_t tx_data_o;

  entry_t         entries[$];
  string          names[$];
  usb_pkg::byte_t exp_bytes[$];
  int             exp_lens[$];
  usb_pkg::byte_t cap_bytes[$];
  int             cap_lens[$];
  logic [8:0]     bulk_model[$];  // {tlast, data}
  int             cur_len;
  int             errors;
  int             ep0_offset;
  logic           ep0_toggle;
  logic           bulk_toggle;
  logic           rand_ready_en;

  usb_device_top UUT (
    .clock           (clock),
    .areset_n        (areset_n),
    .rx_valid_i      (rx_valid_i),
    .rx_last_i       (rx_last_i),
    .rx_data_i       (rx_data_i),
    .s_axis_tvalid_i (s_axis_tvalid_i),
    .s_axis_tlast_i  (s_axis_tlast_i),
    .s_axis_tdata_i  (s_axis_tdata_i),
    .s_axis_tready_o (s_axis_tready_o),
    .tx_ready_i      (tx_ready_i),
    .tx_valid_o      (tx_valid_o),
    .tx_last_o       (tx_last_o),
    .tx_data_o       (tx_data_o)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // valid and ready are stable at the falling edge
  always @(negedge clock) begin
    if (areset_n && tx_valid_o && tx_ready_i) begin
      cap_bytes.push_back(tx_data_o);
      cur_len++;
      if (tx_last_o) begin
        cap_lens.push_back(cur_len);
        cur_len = 0;
      end
    end
  end

  function automatic void add_entry(input string name, input int n_bulk, input int last_at,
                                    input logic [23:0] tok, input int tok_len,
                                    input logic follow, input logic rnd);
    entry_t e;
    e = '{n_bulk, last_at, tok, tok_len, follow, rnd};
    names.push_back(name);
    entries.push_back(e);
  endfunction

  task automatic build_table();
    for (int i = 0; i < 6; i++) begin
      add_entry($sformatf("ep0_chunk%0d", i), 0, 0, 24'h00_05_69, 3, 1'b0, 1'b0);
    end
    add_entry("bulk_tlast5",    5,  5,  TOK_EP1,      3, 1'b0, 1'b0);
    add_entry("bulk12_first",   12, 12, TOK_EP1,      3, 1'b0, 1'b0);
    add_entry("bulk12_rest",    0,  0,  TOK_EP1,      3, 1'b0, 1'b0);
    add_entry("bulk_fill16",    16, 16, TOK_EP1,      3, 1'b0, 1'b0);  // FIFO full
    add_entry("bulk16_rest",    0,  0,  TOK_EP1,      3, 1'b0, 1'b0);
    add_entry("bulk_empty_nak", 0,  0,  TOK_EP1,      3, 1'b0, 1'b0);
    add_entry("bad_pid_check",  0,  0,  24'h00_05_79, 3, 1'b0, 1'b0);
    add_entry("wrong_addr",     0,  0,  24'h00_06_69, 3, 1'b0, 1'b0);
    add_entry("out_pid",        0,  0,  24'h00_05_E1, 3, 1'b0, 1'b0);
    add_entry("short_token",    0,  0,  24'h00_05_69, 2, 1'b0, 1'b0);
    add_entry("endp3",          0,  0,  24'h01_85_69, 3, 1'b0, 1'b0);
    add_entry("rand_ep0_a",     0,  0,  24'h00_05_69, 3, 1'b0, 1'b1);
    add_entry("rand_ep0_b",     0,  0,  24'h00_05_69, 3, 1'b0, 1'b1);
    add_entry("rand_bulk",      7,  7,  TOK_EP1,      3, 1'b0, 1'b1);
    add_entry("overlap",        3,  3,  24'h00_05_69, 3, 1'b1, 1'b0);
    add_entry("overlap_rand",   6,  6,  24'h00_05_69, 3, 1'b1, 1'b1);
  endtask

  task automatic drive_ready();
    forever begin
      @(posedge clock);
      tx_ready_i <= rand_ready_en ? (($urandom % 4) != 0) : 1'b1;  // about 3 in 4
    end
  endtask

  task automatic watchdog(input int cycles);
    repeat (cycles) @(posedge clock);
    $display("timeout: run still busy after %0d cycles", cycles);
    $display("errors: %0d", errors + 1);
    $display("Checks failed");
    $finish;
  endtask

  task automatic preload_bulk(input string name, input int n, input int last_at);
    usb_pkg::byte_t d;
    logic           l;
    logic           exp_ready;
    for (int i = 1; i <= n; i++) begin
      d = usb_pkg::byte_t'($urandom);
      l = (i == last_at);
      s_axis_tvalid_i <= 1'b1;
      s_axis_tdata_i  <= d;
      s_axis_tlast_i  <= l;
      bulk_model.push_back({l, d});
      @(posedge clock);
      while (!s_axis_tready_o) @(posedge clock);  // FIFO full
    end
    s_axis_tvalid_i <= 1'b0;
    s_axis_tlast_i  <= 1'b0;
    @(negedge clock);  // FIFO count settled, nothing draining
    exp_ready = bulk_model.size() < usb_pkg::FIFO_DEPTH;
    assert (s_axis_tready_o == exp_ready) else begin
      errors++;
      $display("Mismatch %s s_axis_tready_o: expected %b, actual %b", name, exp_ready,
               s_axis_tready_o);
    end
    @(posedge clock);
  endtask

  task automatic send_token(input logic [23:0] tok, input int len);
    for (int i = 0; i < len; i++) begin
      rx_valid_i <= 1'b1;
      rx_last_i  <= (i == len - 1);
      rx_data_i  <= tok[i*8 +: 8];
      @(posedge clock);
    end
    rx_valid_i <= 1'b0;
    rx_last_i  <= 1'b0;
  endtask

  // model of both endpoints answering one IN token
  task automatic expect_token(input int ep);
    usb_pkg::byte_t payload[$];
    logic [8:0]     ent;
    logic           done;
    int             len;
    if (ep == 0) begin
      len = chunk_len(ep0_offset);
      for (int i = 0; i < len; i++) begin
        payload.push_back(desc_byte(ep0_offset + i));
      end
      append_packet(exp_bytes, exp_lens,
                    ep0_toggle ? usb_pkg::PID_DATA1 : usb_pkg::PID_DATA0, 1'b0, payload);
      ep0_toggle = ~ep0_toggle;
      ep0_offset = (ep0_offset + len) % usb_pkg::CONF_DESC_LEN;  // wrap to 0
    end else if (ep == 1 && bulk_model.size() == 0) begin
      append_packet(exp_bytes, exp_lens, usb_pkg::PID_NAK, 1'b1, payload);  // toggle kept
    end else if (ep == 1) begin
      done = 1'b0;
      while (!done) begin
        ent = bulk_model.pop_front();
        payload.push_back(ent[7:0]);
        done = ent[8] || payload.size() == usb_pkg::MAX_PKT || bulk_model.size() == 0;
      end
      append_packet(exp_bytes, exp_lens,
                    bulk_toggle ? usb_pkg::PID_DATA1 : usb_pkg::PID_DATA0, 1'b0, payload);
      bulk_toggle = ~bulk_toggle;
    end
  endtask

  task automatic compare_packets(input string name);
    int n;
    int len;
    int epos;
    int cpos;
    n    = (cap_lens.size() < exp_lens.size()) ? cap_lens.size() : exp_lens.size();
    epos = 0;
    cpos = 0;
    assert (cap_lens.size() >= exp_lens.size()) else begin
      errors++;
      $display("%s: %0d packets expected but only %0d arrived", name, exp_lens.size(),
               cap_lens.size());
    end
    assert (cap_lens.size() <= exp_lens.size()) else begin
      errors++;
      $display("%s: %0d extra packets were sent", name, cap_lens.size() - exp_lens.size());
    end
    assert (cur_len == 0) else begin
      errors++;
      $display("%s: a packet was left without its last byte", name);
    end
    for (int p = 0; p < n; p++) begin
      assert (cap_lens[p] == exp_lens[p]) else begin
        errors++;
        $display("Mismatch %s packet %0d length: expected %0d, actual %0d", name, p,
                 exp_lens[p], cap_lens[p]);
      end
      len = (cap_lens[p] < exp_lens[p]) ? cap_lens[p] : exp_lens[p];
      for (int b = 0; b < len; b++) begin
        assert (cap_bytes[cpos+b] == exp_bytes[epos+b]) else begin
          errors++;
          $display("Mismatch %s packet %0d byte %0d: expected %h, actual %h", name, p, b,
                   exp_bytes[epos+b], cap_bytes[cpos+b]);
        end
      end
      epos += exp_lens[p];
      cpos += cap_lens[p];
    end
  endtask

  task automatic run_entry(input int k);
    entry_t e;
    int     waited;
    e = entries[k];
    exp_bytes.delete();
    exp_lens.delete();
    cap_bytes.delete();
    cap_lens.delete();
    rand_ready_en <= e.rand_ready;
    preload_bulk(names[k], e.n_bulk, e.last_at);
    send_token(e.tok, e.tok_len);
    expect_token(token_target(e.tok, e.tok_len));
    if (e.follow_ep1) begin
      send_token(TOK_EP1, 3);  // lands while the first packet is going out
      expect_token(1);
    end
    waited = 0;
    while (cap_lens.size() < exp_lens.size() && waited < PKT_WAIT) begin
      @(posedge clock);
      waited++;
    end
    repeat (SETTLE_CYCLES) @(posedge clock);  // extra packets would show up here
    compare_packets(names[k]);
  endtask

  initial begin
    int limit;
    areset_n        = 1'b0;
    rx_valid_i      = 1'b0;
    rx_last_i       = 1'b0;
    rx_data_i       = '0;
    s_axis_tvalid_i = 1'b0;
    s_axis_tlast_i  = 1'b0;
    s_axis_tdata_i  = '0;
    tx_ready_i      = 1'b1;
    rand_ready_en   = 1'b0;
    cur_len         = 0;
    errors          = 0;
    ep0_offset      = 0;
    ep0_toggle      = 1'b0;  // DATA0 after reset
    bulk_toggle     = 1'b0;
    void'($urandom(32'h8041_fb47));
    build_table();
    limit = RESET_CYCLES + entries.size() * CYCLES_PER_ENTRY;
    fork
      watchdog(limit);
      drive_ready();
    join_none
    repeat (RESET_CYCLES) @(posedge clock);
    areset_n <= 1'b1;
    repeat (4) @(posedge clock);
    for (int k = 0; k < entries.size(); k++) begin
      run_entry(k);
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
